// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - cpuPkg.sv
  - aluUnit.sv
  - registerFile.sv
  - controlDecoder.sv
  - datapath.sv
  - cpuTop.sv
  - target: test
    files:
      - memoryModel.sv
      - cpuTb.sv

// ==== aluUnit.sv ====
module aluUnit (
    input  logic [cpuPkg::wordSize-1:0] aluA,
    input  logic [cpuPkg::wordSize-1:0] aluB,
    input  cpuPkg::aluOpT               aluOp,
    output logic [cpuPkg::wordSize-1:0] aluResult,
    output logic                        isZero,
    output logic                        isNegative
);
    import cpuPkg::*;

    always_comb begin
        case (aluOp)
            aluAdd: aluResult = aluA + aluB;
            aluSub: aluResult = aluA - aluB;
            aluAnd: aluResult = aluA & aluB;
            aluOr: aluResult = aluA | aluB;
            aluNot: aluResult = ~aluA;
            aluTcp: aluResult = ~aluA + wordSize'(1);
            aluShl: aluResult = {aluA[wordSize-2:0], 1'b0};
            aluShr: aluResult = {aluA[wordSize-1], aluA[wordSize-1:1]}; // Keeps the sign bit
            aluPassB: aluResult = aluB;
            aluLink: aluResult = aluA + wordSize'(1);
            default: aluResult = '0;
        endcase
    end

    // Branch decisions in the datapath rely only on these two flags
    assign isZero = (aluResult == '0);
    assign isNegative = aluResult[wordSize-1];

endmodule

// ==== controlDecoder.sv ====
module controlDecoder (
    input  logic [cpuPkg::wordSize-1:0]     instruction,
    output logic [cpuPkg::controlWidth-1:0] controls,
    output cpuPkg::aluOpT                   aluOp
);
    import cpuPkg::*;

    opcodeT opcode;
    funcT func;
    aluOpT aluSel;

    assign opcode = opcodeT'(instruction[15:12]);
    assign func = funcT'(instruction[5:0]);

    always_comb begin
        controls = '0;
        aluSel = aluAdd;
        case (opcode)
            opBne, opBeq: begin
                controls[ctrlBranch] = 1'b1;
                aluSel = aluSub; // Compare rs with rt
            end
            opBgz, opBlz: begin
                controls[ctrlBranch] = 1'b1;
                aluSel = aluPassB; // Datapath routes rs to operand B
            end
            opAdi, opOri, opLhi: begin
                controls[ctrlRegWrite] = 1'b1;
                controls[ctrlAluSrc] = 1'b1;
                aluSel = (opcode == opAdi) ? aluAdd : (opcode == opOri) ? aluOr : aluPassB;
            end
            opLwd: begin
                controls[ctrlMemRead] = 1'b1;
                controls[ctrlMemToReg] = 1'b1;
                controls[ctrlRegWrite] = 1'b1;
                controls[ctrlAluSrc] = 1'b1;
            end
            opSwd: begin
                controls[ctrlMemWrite] = 1'b1;
                controls[ctrlAluSrc] = 1'b1;
            end
            opJmp: controls[ctrlJump] = 1'b1;
            opJal: begin
                controls[ctrlJump] = 1'b1;
                controls[ctrlRegWrite] = 1'b1;
                aluSel = aluLink;
            end
            opRtype: begin
                case (func)
                    fnAdd, fnSub, fnAnd, fnOrr, fnNot, fnTcp, fnShl, fnShr: begin
                        controls[ctrlRegWrite] = 1'b1;
                        controls[ctrlRegDst] = 1'b1;
                        aluSel = aluOpT'(func[3:0]); // Function codes 0 to 7 line up with the ALU ops
                    end
                    fnJpr: controls[ctrlJump] = 1'b1;
                    fnJrl: begin
                        controls[ctrlJump] = 1'b1;
                        controls[ctrlRegWrite] = 1'b1;
                        aluSel = aluLink;
                    end
                    default: controls = '0; // HLT is caught by the datapath
                endcase
            end
            default: controls = '0;
        endcase
        controls[aluOpMsb:aluOpLsb] = aluSel;
    end

    assign aluOp = aluSel;

endmodule

// ==== cpuPkg.sv ====
package cpuPkg;

    localparam int wordSize = 16;
    localparam int numRegs = 4;
    localparam int regAddrWidth = 2;
    localparam int controlWidth = 12;

    localparam int ctrlJump = 11;
    localparam int ctrlBranch = 10;
    localparam int ctrlMemToReg = 9;
    localparam int ctrlMemRead = 8;
    localparam int ctrlMemWrite = 7;
    localparam int ctrlRegDst = 6;
    localparam int ctrlRegWrite = 5;
    localparam int aluOpMsb = 4;
    localparam int aluOpLsb = 1;
    localparam int ctrlAluSrc = 0;

    localparam logic [regAddrWidth-1:0] linkReg = 2; // Return address register of JAL and JRL

    typedef enum logic [3:0] {
        opBne = 4'd0,
        opBeq = 4'd1,
        opBgz = 4'd2,
        opBlz = 4'd3,
        opAdi = 4'd4,
        opOri = 4'd5,
        opLhi = 4'd6,
        opLwd = 4'd7,
        opSwd = 4'd8,
        opJmp = 4'd9,
        opJal = 4'd10,
        opRtype = 4'd15
    } opcodeT;

    typedef enum logic [5:0] {
        fnAdd = 6'd0,
        fnSub = 6'd1,
        fnAnd = 6'd2,
        fnOrr = 6'd3,
        fnNot = 6'd4,
        fnTcp = 6'd5,
        fnShl = 6'd6,
        fnShr = 6'd7,
        fnJpr = 6'd25,
        fnJrl = 6'd26,
        fnHlt = 6'd29
    } funcT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluNot, aluTcp, aluShl, aluShr,
        aluPassB, // Operand B unchanged, LHI feeds it the shifted immediate
        aluLink // Operand A plus one
    } aluOpT;

    typedef enum logic [2:0] {
        stFetch, stExecute, stMemory, stWriteBack, stHalt
    } cpuStateT;

endpackage

// ==== cpuTb.sv ====
module cpuTb;
    timeunit 1ns;
    timeprecision 100ps;

    import cpuPkg::*;

    localparam int memDepth = 256;
    localparam int resetCycles = 4;
    localparam int haltTimeout = 2000;
    localparam int haltWatchCycles = 50;
    localparam logic [15:0] arithBase = 16'h0080;

    logic clk = 1'b0;
    logic reset;
    logic randomDelay;
    logic readM;
    logic writeM;
    logic [15:0] address;
    logic [15:0] writeData;
    logic [15:0] readData;
    logic inputReady;
    logic ackOutput;
    logic halted;

    string currentTest;
    int testCount = 0;
    int checkCount = 0;
    int errorCount = 0;
    int errorsAtStart = 0;
    int loadPtr = 0;
    logic [15:0] readLog [$];
    int readsAtFirstWrite = -1;
    logic readPrev = 1'b0;

    cpuTop u_cpuTop (
        .clk(clk), .reset(reset), .readM(readM), .writeM(writeM),
        .address(address), .writeData(writeData), .readData(readData),
        .inputReady(inputReady), .ackOutput(ackOutput), .halted(halted)
    );

    memoryModel #(.depth(memDepth)) u_memoryModel (
        .clk(clk), .reset(reset), .randomDelay(randomDelay),
        .readM(readM), .writeM(writeM), .address(address), .writeData(writeData),
        .readData(readData), .inputReady(inputReady), .ackOutput(ackOutput)
    );

    always #2 clk = ~clk;

    // Each rising edge of readM starts a request whose address goes into the log
    always @(posedge clk) begin
        if (reset) begin
            readPrev = 1'b0;
        end else begin
            if (readM && !readPrev) begin
                readLog.push_back(address);
            end
            if (writeM && readsAtFirstWrite < 0) begin
                readsAtFirstWrite = readLog.size();
            end
            readPrev = readM;
        end
    end

    function automatic logic [15:0] immWord(input logic [3:0] op, input logic [1:0] rs,
                                            input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] regWord(input logic [1:0] rs, input logic [1:0] rt,
                                            input logic [1:0] rd, input logic [5:0] fn);
        return {4'hF, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] jumpWord(input logic [3:0] op, input logic [11:0] target);
        return {op, target};
    endfunction

    function automatic logic [15:0] fillPattern(input logic [15:0] a);
        return {a[7:0] ^ a[15:8] ^ 8'h5A, ~a[7:0]};
    endfunction

    function automatic logic [15:0] arithResult(input int k, input logic [15:0] a,
                                                input logic [15:0] b);
        case (k)
            0: return a + b;
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return ~a;
            5: return 16'd0 - a;
            6: return a << 1;
            7: return 16'($signed(a) >>> 1);
            8: return a;
            default: return b;
        endcase
    endfunction

    function automatic logic branchRule(input logic [3:0] op, input logic [15:0] rsVal,
                                        input logic [15:0] rtVal);
        case (op)
            opBne: return rsVal != rtVal;
            opBeq: return rsVal == rtVal;
            opBgz: return $signed(rsVal) > 0;
            default: return $signed(rsVal) < 0;
        endcase
    endfunction

    task automatic emit(input logic [15:0] word);
        u_memoryModel.loadWord(16'(loadPtr), word);
        loadPtr++;
    endtask

    task automatic fillMemory();
        for (int a = 0; a < memDepth; a++) begin
            u_memoryModel.loadWord(16'(a), fillPattern(16'(a)));
        end
        loadPtr = 0;
    endtask

    task automatic checkValue(input string what, input logic [15:0] expected,
                              input logic [15:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED %s %s: expected %h, actual %h", currentTest, what, expected, actual);
        end
    endtask

    task automatic startTest(input string name);
        currentTest = name;
        errorsAtStart = errorCount;
        testCount++;
    endtask

    task automatic endTest();
        $display("%s: done, %0d errors", currentTest, errorCount - errorsAtStart);
    endtask

    task automatic runProgram(input logic useRandom);
        int cycles;
        @(posedge clk);
        reset <= 1'b1;
        randomDelay <= useRandom;
        repeat (resetCycles) @(posedge clk);
        readLog.delete();
        readsAtFirstWrite = -1;
        checkValue("readM after reset", 16'd0, 16'(readM));
        checkValue("writeM after reset", 16'd0, 16'(writeM));
        checkValue("halted after reset", 16'd0, 16'(halted));
        reset <= 1'b0;
        cycles = 0;
        while (halted !== 1'b1 && cycles < haltTimeout) begin
            @(posedge clk);
            cycles++;
        end
        if (halted !== 1'b1) begin
            errorCount++;
            $display("%s: the core did not halt within %0d cycles", currentTest, haltTimeout);
        end
    endtask

    task automatic loadArithProgram();
        emit(immWord(opLhi, 0, 1, 8'hA5));
        emit(immWord(opOri, 1, 1, 8'h3C));
        emit(immWord(opAdi, 0, 2, 8'hF9)); // Negative immediate
        emit(immWord(opOri, 0, 3, arithBase[7:0]));
        for (int k = 0; k < 8; k++) begin
            emit(regWord(1, 2, 0, 6'(k))); // Functions 0 to 7 are ADD to SHR
            emit(immWord(opSwd, 3, 0, 8'(k)));
        end
        emit(immWord(opSwd, 3, 1, 8'd8));
        emit(immWord(opSwd, 3, 2, 8'd9));
        emit(regWord(0, 0, 0, fnHlt));
    endtask

    task automatic checkArith();
        string names [10] = '{"ADD", "SUB", "AND", "ORR", "NOT", "TCP", "SHL", "SHR",
                              "LHI/ORI", "ADI"};
        logic [15:0] a;
        logic [15:0] b;
        a = {8'hA5, 8'h00} | {8'h00, 8'h3C};
        b = 16'($signed(8'hF9));
        for (int k = 0; k < 10; k++) begin
            checkValue(names[k], arithResult(k, a, b),
                       u_memoryModel.peekWord(arithBase + 16'(k)));
        end
    endtask

    task automatic resetFetchTest();
        startTest("resetFetch");
        fillMemory();
        emit(immWord(opAdi, 0, 0, 8'd1));
        emit(immWord(opAdi, 0, 0, 8'd1));
        emit(immWord(opOri, 1, 1, 8'hE0));
        emit(immWord(opAdi, 0, 0, 8'd1));
        emit(immWord(opSwd, 1, 0, 8'd0));
        emit(regWord(0, 0, 0, fnHlt));
        runProgram(1'b0);
        checkValue("fetch count", 16'd6, 16'(readLog.size()));
        for (int i = 0; i < readLog.size() && i < 6; i++) begin
            checkValue($sformatf("fetch %0d address", i), 16'(i), readLog[i]);
        end
        checkValue("fetches before first write", 16'd5, 16'(readsAtFirstWrite));
        checkValue("stored sum", 16'd3, u_memoryModel.peekWord(16'h00E0));
        endTest();
    endtask

    task automatic arithmeticTest();
        startTest("arithmetic");
        fillMemory();
        loadArithProgram();
        runProgram(1'b0);
        checkArith();
        endTest();
    endtask

    task automatic loadStoreTest();
        int base = 'h90;
        logic [15:0] lowWord = 16'h5AC3;
        logic [15:0] highWord = 16'h0F1E;
        logic [15:0] expected;
        startTest("loadStore");
        fillMemory();
        u_memoryModel.loadWord(16'(base - 3), lowWord);
        u_memoryModel.loadWord(16'(base + 5), highWord);
        emit(immWord(opOri, 0, 1, 8'(base)));
        emit(immWord(opLwd, 1, 2, 8'hFD));
        emit(immWord(opLwd, 1, 0, 8'd5));
        emit(immWord(opSwd, 1, 2, 8'h10));
        emit(immWord(opSwd, 1, 0, 8'h11));
        emit(regWord(0, 0, 0, fnHlt));
        runProgram(1'b0);
        for (int a = 'h88; a < 'hA8; a++) begin
            if (a == base - 3 || a == base + 'h10) begin
                expected = lowWord;
            end else if (a == base + 5 || a == base + 'h11) begin
                expected = highWord;
            end else begin
                expected = fillPattern(16'(a));
            end
            checkValue($sformatf("mem[%h]", a), expected, u_memoryModel.peekWord(16'(a)));
        end
        endTest();
    endtask

    task automatic branchTest();
        logic [3:0] ops [8] = '{opBne, opBne, opBeq, opBeq, opBgz, opBgz, opBlz, opBlz};
        int rsSel [8] = '{0, 0, 0, 0, 0, 2, 2, 0};
        int rtSel [8] = '{1, 2, 1, 2, 0, 0, 0, 0};
        logic [15:0] regVals [4] = '{16'd5, 16'd5, 16'hFFFD, 16'h00C0};
        int start;
        logic taken;
        logic [15:0] slot;
        startTest("branch");
        fillMemory();
        emit(immWord(opAdi, 0, 0, 8'd5));
        emit(immWord(opAdi, 1, 1, 8'd5));
        emit(immWord(opAdi, 2, 2, 8'hFD));
        emit(immWord(opOri, 3, 3, regVals[3][7:0]));
        for (int k = 0; k < 8; k++) begin
            start = loadPtr;
            emit(immWord(ops[k], 2'(rsSel[k]), 2'(rtSel[k]), 8'd2));
            emit(immWord(opSwd, 3, 1, 8'(2 * k))); // Not-taken marker
            emit(jumpWord(opJmp, 12'(start + 4)));
            emit(immWord(opSwd, 3, 1, 8'(2 * k + 1))); // Taken marker
        end
        emit(regWord(0, 0, 0, fnHlt));
        runProgram(1'b0);
        for (int k = 0; k < 8; k++) begin
            taken = branchRule(ops[k], regVals[rsSel[k]], regVals[rtSel[k]]);
            slot = regVals[3] + 16'(2 * k);
            checkValue($sformatf("case %0d fall-through marker", k),
                       taken ? fillPattern(slot) : regVals[1], u_memoryModel.peekWord(slot));
            checkValue($sformatf("case %0d taken marker", k),
                       taken ? regVals[1] : fillPattern(slot + 16'd1),
                       u_memoryModel.peekWord(slot + 16'd1));
        end
        endTest();
    endtask

    task automatic jumpTest();
        int jalAt = 4;
        int jrlAt = 7;
        logic [15:0] base = 16'h00D0;
        startTest("jumpLink");
        fillMemory();
        emit(immWord(opOri, 0, 3, base[7:0]));
        emit(immWord(opOri, 0, 1, 8'h11));
        emit(jumpWord(opJmp, 12'd4));
        emit(immWord(opSwd, 3, 1, 8'd0)); // Skipped by JMP
        emit(jumpWord(opJal, 12'd10));
        emit(immWord(opSwd, 3, 1, 8'd3)); // Return point of JPR
        emit(immWord(opOri, 0, 0, 8'd14));
        emit(regWord(0, 0, 0, fnJrl));
        emit(immWord(opSwd, 3, 1, 8'd4)); // Skipped by JRL
        emit(regWord(0, 0, 0, fnHlt));
        emit(immWord(opSwd, 3, 2, 8'd1));
        emit(regWord(2, 0, 0, fnJpr));
        emit(regWord(0, 0, 0, fnHlt));
        emit(regWord(0, 0, 0, fnHlt));
        emit(immWord(opSwd, 3, 2, 8'd2));
        emit(regWord(0, 0, 0, fnHlt));
        runProgram(1'b0);
        checkValue("JMP skipped marker", fillPattern(base), u_memoryModel.peekWord(base));
        checkValue("JAL link", 16'(jalAt + 1), u_memoryModel.peekWord(base + 16'd1));
        checkValue("JRL link", 16'(jrlAt + 1), u_memoryModel.peekWord(base + 16'd2));
        checkValue("JPR return marker", 16'h0011, u_memoryModel.peekWord(base + 16'd3));
        checkValue("JRL skipped marker", fillPattern(base + 16'd4),
                   u_memoryModel.peekWord(base + 16'd4));
        endTest();
    endtask

    task automatic stallHaltTest();
        startTest("stallHalt");
        fillMemory();
        loadArithProgram();
        runProgram(1'b1);
        checkArith();
        // The core must stay parked with no fetch activity
        for (int i = 0; i < haltWatchCycles; i++) begin
            @(posedge clk);
            checkValue($sformatf("halted at cycle %0d", i), 16'd1, 16'(halted));
            checkValue($sformatf("readM at cycle %0d", i), 16'd0, 16'(readM));
        end
        endTest();
    endtask

    initial begin
        reset = 1'b1;
        randomDelay = 1'b0;
        resetFetchTest();
        arithmeticTest();
        loadStoreTest();
        branchTest();
        jumpTest();
        stallHaltTest();
        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== cpuTop.sv ====
module cpuTop (
    input  logic                        clk,
    input  logic                        reset,
    output logic                        readM,
    output logic                        writeM,
    output logic [cpuPkg::wordSize-1:0] address,
    output logic [cpuPkg::wordSize-1:0] writeData,
    input  logic [cpuPkg::wordSize-1:0] readData,
    input  logic                        inputReady,
    input  logic                        ackOutput,
    output logic                        halted
);
    import cpuPkg::*;

    logic [wordSize-1:0] instruction;
    logic [controlWidth-1:0] controls;
    aluOpT aluOp;
    logic [regAddrWidth-1:0] readAddr1;
    logic [regAddrWidth-1:0] readAddr2;
    logic [regAddrWidth-1:0] writeAddr;
    logic [wordSize-1:0] regWriteData;
    logic regWriteEnable;
    logic [wordSize-1:0] readData1;
    logic [wordSize-1:0] readData2;
    logic [wordSize-1:0] aluA;
    logic [wordSize-1:0] aluB;
    logic [wordSize-1:0] aluResult;
    logic isZero;
    logic isNegative;

    controlDecoder u_controlDecoder (
        .instruction(instruction),
        .controls(controls),
        .aluOp(aluOp)
    );

    datapath u_datapath (
        .clk(clk), .reset(reset), .controls(controls), .aluOp(aluOp),
        .instruction(instruction),
        .readAddr1(readAddr1), .readAddr2(readAddr2), .writeAddr(writeAddr),
        .writeData(regWriteData), .writeEnable(regWriteEnable),
        .readData1(readData1), .readData2(readData2),
        .aluA(aluA), .aluB(aluB), .aluResult(aluResult),
        .isZero(isZero), .isNegative(isNegative),
        .readM(readM), .writeM(writeM), .address(address), .memWriteData(writeData),
        .readData(readData), .inputReady(inputReady), .ackOutput(ackOutput),
        .halted(halted)
    );

    registerFile u_registerFile (
        .clk(clk), .reset(reset),
        .readAddr1(readAddr1), .readAddr2(readAddr2), .writeAddr(writeAddr),
        .writeData(regWriteData), .writeEnable(regWriteEnable),
        .readData1(readData1), .readData2(readData2)
    );

    aluUnit u_aluUnit (
        .aluA(aluA), .aluB(aluB), .aluOp(aluOp),
        .aluResult(aluResult), .isZero(isZero), .isNegative(isNegative)
    );

endmodule

// ==== datapath.sv ====
module datapath (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [cpuPkg::controlWidth-1:0] controls,
    input  cpuPkg::aluOpT                   aluOp,
    output logic [cpuPkg::wordSize-1:0]     instruction,
    output logic [cpuPkg::regAddrWidth-1:0] readAddr1,
    output logic [cpuPkg::regAddrWidth-1:0] readAddr2,
    output logic [cpuPkg::regAddrWidth-1:0] writeAddr,
    output logic [cpuPkg::wordSize-1:0]     writeData,
    output logic                            writeEnable,
    input  logic [cpuPkg::wordSize-1:0]     readData1,
    input  logic [cpuPkg::wordSize-1:0]     readData2,
    output logic [cpuPkg::wordSize-1:0]     aluA,
    output logic [cpuPkg::wordSize-1:0]     aluB,
    input  logic [cpuPkg::wordSize-1:0]     aluResult,
    input  logic                            isZero,
    input  logic                            isNegative,
    output logic                            readM,
    output logic                            writeM,
    output logic [cpuPkg::wordSize-1:0]     address,
    output logic [cpuPkg::wordSize-1:0]     memWriteData,
    input  logic [cpuPkg::wordSize-1:0]     readData,
    input  logic                            inputReady,
    input  logic                            ackOutput,
    output logic                            halted
);
    import cpuPkg::*;

    cpuStateT state;
    cpuStateT nextState;
    logic [wordSize-1:0] pc;
    logic [wordSize-1:0] pcPlusOne;
    logic [wordSize-1:0] nextPc;
    logic [wordSize-1:0] instructionReg;
    logic [wordSize-1:0] memDataReg;
    logic [wordSize-1:0] aluOut;
    logic [wordSize-1:0] immExt;
    logic [7:0] imm;
    opcodeT opcode;
    logic isHalt;
    logic branchTaken;

    assign instruction = instructionReg;
    assign opcode = opcodeT'(instructionReg[15:12]);
    assign imm = instructionReg[7:0];
    assign isHalt = (opcode == opRtype) && (funcT'(instructionReg[5:0]) == fnHlt);
    assign pcPlusOne = pc + wordSize'(1);

    always_comb begin
        case (opcode)
            opOri: immExt = {{(wordSize-8){1'b0}}, imm};
            opLhi: immExt = {imm, 8'h00};
            default: immExt = {{(wordSize-8){imm[7]}}, imm};
        endcase
    end

    // Register file and ALU operands
    assign readAddr1 = instructionReg[11:10];
    assign readAddr2 = instructionReg[9:8];
    assign aluA = (aluOp == aluLink) ? pc : readData1;
    always_comb begin
        if (controls[ctrlAluSrc]) begin
            aluB = immExt;
        end else if (controls[ctrlBranch] && aluOp == aluPassB) begin
            aluB = readData1; // BGZ and BLZ test rs alone
        end else begin
            aluB = readData2;
        end
    end

    always_comb begin
        case (opcode)
            opBne: branchTaken = !isZero;
            opBeq: branchTaken = isZero;
            opBgz: branchTaken = !isZero && !isNegative;
            opBlz: branchTaken = isNegative;
            default: branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        if (controls[ctrlJump]) begin
            nextPc = (opcode == opRtype) ? readData1 : {pcPlusOne[wordSize-1:12], instructionReg[11:0]};
        end else if (controls[ctrlBranch] && branchTaken) begin
            nextPc = pcPlusOne + immExt;
        end else begin
            nextPc = pcPlusOne;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            stFetch: begin
                if (inputReady) begin
                    nextState = stExecute;
                end
            end
            stExecute: begin
                if (isHalt) begin
                    nextState = stHalt;
                end else if (controls[ctrlMemRead] || controls[ctrlMemWrite]) begin
                    nextState = stMemory;
                end else begin
                    nextState = stWriteBack;
                end
            end
            stMemory: begin
                if ((controls[ctrlMemRead] && inputReady) || (controls[ctrlMemWrite] && ackOutput)) begin
                    nextState = stWriteBack;
                end
            end
            stWriteBack: nextState = stFetch;
            default: nextState = stHalt; // Only reset leaves the halt state
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stFetch;
            pc <= '0;
            readM <= 1'b0;
            writeM <= 1'b0;
        end else begin
            state <= nextState;
            readM <= (nextState == stFetch) || (nextState == stMemory && controls[ctrlMemRead]);
            writeM <= (nextState == stMemory) && controls[ctrlMemWrite];
            if (state == stExecute) begin
                pc <= nextPc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == stFetch && inputReady) begin
            instructionReg <= readData;
        end
        if (state == stExecute) begin
            aluOut <= aluResult; // Also holds the link value and the load/store address
        end
        if (state == stMemory && controls[ctrlMemRead] && inputReady) begin
            memDataReg <= readData;
        end
    end

    // Writeback and memory port
    assign writeEnable = (state == stWriteBack) && controls[ctrlRegWrite];
    assign writeData = controls[ctrlMemToReg] ? memDataReg : aluOut;
    always_comb begin
        if (aluOp == aluLink) begin
            writeAddr = linkReg;
        end else begin
            writeAddr = controls[ctrlRegDst] ? instructionReg[7:6] : instructionReg[9:8];
        end
    end
    assign address = (state == stFetch) ? pc : aluOut;
    assign memWriteData = readData2;
    assign halted = (state == stHalt);

    strobesExclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(readM && writeM)
    );

    writeOnlyInStore: assert property (
        @(posedge clk) disable iff (reset)
        writeM |-> (state == stMemory) && controls[ctrlMemWrite]
    );

    // A pending read keeps its strobe and address until the memory answers
    readHeld: assert property (
        @(posedge clk) disable iff (reset)
        readM && !inputReady |=> readM && $stable(address)
    );

endmodule

// ==== files.f ====
cpuPkg.sv
aluUnit.sv
registerFile.sv
controlDecoder.sv
datapath.sv
cpuTop.sv
memoryModel.sv
cpuTb.sv

// ==== memoryModel.sv ====
module memoryModel #(
    parameter int depth = 256
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        randomDelay,
    input  logic        readM,
    input  logic        writeM,
    input  logic [15:0] address,
    input  logic [15:0] writeData,
    output logic [15:0] readData,
    output logic        inputReady,
    output logic        ackOutput
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [15:0] mem [depth];
    integer seed = 32'h611cb303;
    logic busy;
    int countdown;

    initial begin
        readData = '0;
        inputReady = 1'b0;
        ackOutput = 1'b0;
        busy = 1'b0;
        countdown = 0;
    end

    always @(posedge clk) begin
        inputReady <= 1'b0;
        ackOutput <= 1'b0;
        if (reset) begin
            busy <= 1'b0;
        end else if (inputReady || ackOutput) begin
            busy <= 1'b0; // The core drops its strobe on this edge
        end else if (!busy && (readM || writeM)) begin
            busy <= 1'b1;
            countdown <= randomDelay ? ($random(seed) & 3) : 0; // Reply after 1 to 4 cycles
        end else if (busy && countdown > 0) begin
            countdown <= countdown - 1;
        end else if (busy) begin
            if (readM) begin
                readData <= mem[address % depth];
                inputReady <= 1'b1;
            end else begin
                mem[address % depth] = writeData;
                ackOutput <= 1'b1;
            end
        end
    end

    task automatic loadWord(input logic [15:0] addr, input logic [15:0] data);
        mem[addr % depth] = data;
    endtask

    function automatic logic [15:0] peekWord(input logic [15:0] addr);
        return mem[addr % depth];
    endfunction

endmodule

// ==== registerFile.sv ====
module registerFile (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [cpuPkg::regAddrWidth-1:0] readAddr1,
    input  logic [cpuPkg::regAddrWidth-1:0] readAddr2,
    input  logic [cpuPkg::regAddrWidth-1:0] writeAddr,
    input  logic [cpuPkg::wordSize-1:0]     writeData,
    input  logic                            writeEnable,
    output logic [cpuPkg::wordSize-1:0]     readData1,
    output logic [cpuPkg::wordSize-1:0]     readData2
);
    import cpuPkg::*;

    logic [wordSize-1:0] regs [numRegs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readData1 = regs[readAddr1]; // Reads see the old value during a write
    assign readData2 = regs[readAddr2];

    writeAddrKnown: assert property (
        @(posedge clk) disable iff (reset)
        writeEnable |-> !$isunknown(writeAddr)
    );

endmodule
